/* all.f */
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/mips_bus_pkg.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_control.sv
rtl/mips_core.sv
rtl/mips_mem.sv
rtl/mips_host_regs.sv
rtl/mips_system.sv
sim/mips_tb_assertions.sv
sim/mips_tb.sv

/* rtl/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
	import mips_isa_pkg::*;
(
	input logic [31:0] a,
	input logic [31:0] b,
	input alu_class_e alu_class,
	input logic [5:0] funct,
	output logic [31:0] result,
	output logic zero
);

	alu_op_e op;

	// resolve requested class into an operation
	always_comb begin
		case (alu_class)
			cls_add: op = alu_add; // pc increment, addresses, addi
			cls_sub: op = alu_sub; // beq compare
			default: begin
				case (funct)
					fn_sub: op = alu_sub;
					fn_and: op = alu_and;
					fn_or: op = alu_or;
					fn_slt: op = alu_slt;
					default: op = alu_add;
				endcase
			end
		endcase
	end

	always_comb begin
		case (op)
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_slt: result = {31'b0, $signed(a) < $signed(b)}; // signed compare
			default: result = a + b;
		endcase
	end

	assign zero = (result == 32'b0); // beq taken when operands match

endmodule

/* rtl/mips_bus_pkg.sv */
`include "mips_settings.svh"

package mips_bus_pkg;
	import mips_isa_pkg::*;

	// one state per memory phase of the multicycle core
	typedef enum logic [3:0] {
		st_fetch, st_decode, st_mem_addr, st_mem_read, st_mem_wb, st_mem_write,
		st_execute, st_alu_wb, st_branch, st_jump, st_halted, st_idle
	} ctrl_state_e;

	typedef struct packed {
		logic pc_write;
		logic pc_write_cond; // pc update only on alu zero
		logic ir_write;
		logic mem_write;
		logic reg_write;
		logic i_or_d; // memory address from alu_out instead of pc
		logic mem_to_reg;
		logic reg_dst; // rd instead of rt
		logic alu_src_a; // reg a instead of pc
		logic [1:0] alu_src_b; // b, 4, imm, imm << 2
		logic [1:0] pc_source; // alu, alu_out, jump target
		alu_class_e alu_class;
	} ctrl_t;

	typedef struct packed {
		logic [`mips_axil_addr_w-1:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [`mips_axil_addr_w-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

/* rtl/mips_control.sv */
`timescale 1ns/1ps

module mips_control
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;
(
	input logic clk,
	input logic rstb,
	input logic start,
	input instr_u instr,
	output ctrl_t ctrl,
	output ctrl_state_e state,
	output logic retire
);

	ctrl_state_e next_state;
	logic alu_funct; // funct is one the alu implements

	assign alu_funct = instr.r.funct inside {fn_add, fn_sub, fn_and, fn_or, fn_slt};

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle, st_halted: begin
				if (start)
					next_state = st_fetch; // only a new start leaves
			end
			st_fetch: next_state = st_decode;
			st_decode: begin
				case (instr.r.opcode)
					op_r_type: next_state = alu_funct ? st_execute : st_halted; // break
					op_addi: next_state = st_execute;
					op_lw, op_sw: next_state = st_mem_addr;
					op_beq: next_state = st_branch;
					op_j: next_state = st_jump;
					default: next_state = st_halted; // unknown opcode acts as break
				endcase
			end
			st_mem_addr: next_state = (instr.r.opcode == op_lw) ? st_mem_read : st_mem_write;
			st_mem_read: next_state = st_mem_wb;
			st_execute: next_state = st_alu_wb;
			default: next_state = st_fetch; // last state of every instruction
		endcase
	end

	// control word per state
	always_comb begin
		ctrl = '0;
		case (state)
			st_fetch: begin
				ctrl.pc_write = 1'b1; // pc <= pc + 4
				ctrl.alu_src_b = 2'd1;
			end
			st_decode: begin
				ctrl.ir_write = 1'b1;
				ctrl.alu_src_b = 2'd3; // branch target into alu_out
			end
			st_mem_addr: begin
				ctrl.alu_src_a = 1'b1;
				ctrl.alu_src_b = 2'd2; // base + offset
			end
			st_mem_read: ctrl.i_or_d = 1'b1;
			st_mem_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			st_mem_write: begin
				ctrl.i_or_d = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			st_execute: begin
				ctrl.alu_src_a = 1'b1;
				if (instr.r.opcode == op_addi)
					ctrl.alu_src_b = 2'd2;
				else
					ctrl.alu_class = cls_funct;
			end
			st_alu_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst = (instr.r.opcode == op_r_type); // addi writes rt
			end
			st_branch: begin
				ctrl.alu_src_a = 1'b1;
				ctrl.alu_class = cls_sub;
				ctrl.pc_write_cond = 1'b1;
				ctrl.pc_source = 2'd1;
			end
			st_jump: begin
				ctrl.pc_write = 1'b1;
				ctrl.pc_source = 2'd2;
			end
			default: ; // idle and halted drive nothing
		endcase
	end

	assign retire = state inside {st_mem_wb, st_mem_write, st_alu_wb, st_branch, st_jump};

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;
(
	input logic clk,
	input logic rstb,
	input logic start,
	input logic [31:0] mem_rd_data,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wr_data,
	output logic mem_wr_ena,
	output logic busy,
	output logic halted,
	output logic retire,
	output logic [31:0] pc
);

	ctrl_t ctrl;
	ctrl_state_e state;
	instr_u ir;
	instr_u cur_instr; // instruction seen by decode and later states
	logic [31:0] pc_reg, fetch_pc;
	logic [31:0] mdr, reg_a, reg_b, alu_out;
	logic [31:0] rd1, rd2, src_a, src_b, alu_result;
	logic [31:0] sign_ext, wr_data, jump_target, pc_next;
	logic [4:0] wr_reg;
	logic zero, pc_ena, idle_start;

	// ir loads at the end of decode, so decode reads the memory output itself
	assign cur_instr = (state == st_decode) ? instr_u'(mem_rd_data) : ir;
	assign mdr = mem_rd_data; // sync read output already acts as mdr in mem_wb

	mips_control i_mips_control (
		.clk(clk),
		.rstb(rstb),
		.start(start),
		.instr(cur_instr),
		.ctrl(ctrl),
		.state(state),
		.retire(retire)
	);

	assign sign_ext = {{16{cur_instr.i.imm16[15]}}, cur_instr.i.imm16};

	assign src_a = ctrl.alu_src_a ? reg_a : pc_reg;
	always_comb begin
		case (ctrl.alu_src_b)
			2'd0: src_b = reg_b;
			2'd1: src_b = 32'd4;
			2'd2: src_b = sign_ext;
			default: src_b = {sign_ext[29:0], 2'b00}; // word offset
		endcase
	end

	mips_alu i_mips_alu (
		.a(src_a),
		.b(src_b),
		.alu_class(ctrl.alu_class),
		.funct(cur_instr.r.funct),
		.result(alu_result),
		.zero(zero)
	);

	assign wr_reg = ctrl.reg_dst ? ir.r.rd : ir.r.rt;
	assign wr_data = ctrl.mem_to_reg ? mdr : alu_out;

	mips_regfile i_mips_regfile (
		.clk(clk),
		.rstb(rstb),
		.ra1(cur_instr.r.rs),
		.ra2(cur_instr.r.rt),
		.wa(wr_reg),
		.wd(wr_data),
		.we(ctrl.reg_write),
		.rd1(rd1),
		.rd2(rd2)
	);

	// pc update
	assign jump_target = {pc_reg[31:28], ir.j.target26, 2'b00};
	always_comb begin
		case (ctrl.pc_source)
			2'd1: pc_next = alu_out; // branch target from decode
			2'd2: pc_next = jump_target;
			default: pc_next = alu_result;
		endcase
	end
	assign pc_ena = ctrl.pc_write | (ctrl.pc_write_cond & zero);
	assign idle_start = start & ~busy;

	always_ff @(posedge clk) begin
		if (!rstb || idle_start) begin
			pc_reg <= `mips_reset_pc;
			fetch_pc <= `mips_reset_pc;
		end else begin
			if (pc_ena)
				pc_reg <= pc_next;
			if (state == st_fetch)
				fetch_pc <= pc_reg; // address of the instruction in flight
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.ir_write)
			ir <= cur_instr;
		reg_a <= rd1;
		reg_b <= rd2;
		alu_out <= alu_result;
	end

	assign mem_addr = ctrl.i_or_d ? alu_out : pc_reg;
	assign mem_wr_data = reg_b; // sw stores rt
	assign mem_wr_ena = ctrl.mem_write;
	assign busy = !(state inside {st_idle, st_halted});
	assign halted = (state == st_halted);
	assign pc = fetch_pc;

endmodule

/* rtl/mips_host_regs.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_host_regs
	import mips_bus_pkg::*;
(
	input logic clk,
	input logic rstb,
	input axil_req_t req,
	output axil_rsp_t rsp,
	output logic start,
	input logic busy,
	input logic halted,
	input logic retire,
	input logic [31:0] pc,
	output logic host_owns,
	output logic [9:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic [3:0] mem_wstrb,
	output logic mem_we,
	input logic [31:0] mem_rdata
);

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	logic core_busy; // busy, or start already on its way
	logic wr_hs, rd_hs, wr_win, rd_win, wr_is_reg, rd_mapped;
	logic bvalid_q, rvalid_q, rd_mem_q;
	logic [1:0] bresp_q, rresp_q;
	logic [31:0] rdata_q, reg_rdata, retired_q;

	function automatic logic in_window(input logic [`mips_axil_addr_w-1:0] addr);
		return (addr >= `mips_mem_base) && (addr < `mips_mem_base + 4 * `mips_mem_words);
	endfunction

	assign core_busy = busy | start;
	assign host_owns = ~core_busy;

	assign wr_hs = req.awvalid & req.wvalid & ~bvalid_q;
	assign rd_hs = req.arvalid & ~rvalid_q & ~rd_mem_q & ~wr_hs; // write wins the port
	assign wr_win = in_window(req.awaddr) & ~core_busy;
	assign rd_win = in_window(req.araddr) & ~core_busy;
	assign wr_is_reg = req.awaddr inside {`mips_reg_ctrl, `mips_reg_status,
		`mips_reg_retired, `mips_reg_pc};

	assign mem_addr = wr_hs ? req.awaddr[11:2] : req.araddr[11:2];
	assign mem_wdata = req.wdata;
	assign mem_wstrb = req.wstrb;
	assign mem_we = wr_hs & wr_win;

	always_comb begin
		rd_mapped = 1'b1;
		case (req.araddr)
			`mips_reg_ctrl: reg_rdata = '0; // start bit self-clears
			`mips_reg_status: reg_rdata = {30'b0, core_busy, halted};
			`mips_reg_retired: reg_rdata = retired_q;
			`mips_reg_pc: reg_rdata = pc;
			default: begin
				reg_rdata = '0; // unmapped or refused window
				rd_mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			start <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			rd_mem_q <= 1'b0;
			retired_q <= '0;
		end else begin
			start <= wr_hs && (req.awaddr == `mips_reg_ctrl) && req.wstrb[0] && req.wdata[0]
				&& !core_busy;
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (req.bready)
				bvalid_q <= 1'b0;
			rd_mem_q <= rd_hs & rd_win; // sync memory, one extra cycle
			if ((rd_hs && !rd_win) || rd_mem_q)
				rvalid_q <= 1'b1;
			else if (req.rready)
				rvalid_q <= 1'b0;
			if (start)
				retired_q <= '0;
			else if (retire)
				retired_q <= retired_q + 32'd1;
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (wr_hs)
			bresp_q <= (wr_win || wr_is_reg) ? resp_okay : resp_slverr;
		if (rd_hs && !rd_win) begin
			rdata_q <= reg_rdata;
			rresp_q <= rd_mapped ? resp_okay : resp_slverr;
		end else if (rd_mem_q) begin
			rdata_q <= mem_rdata;
			rresp_q <= resp_okay;
		end
	end

	assign rsp.awready = wr_hs;
	assign rsp.wready = wr_hs;
	assign rsp.bresp = bresp_q;
	assign rsp.bvalid = bvalid_q;
	assign rsp.arready = rd_hs;
	assign rsp.rdata = rdata_q;
	assign rsp.rresp = rresp_q;
	assign rsp.rvalid = rvalid_q;

endmodule

/* rtl/mips_isa_pkg.sv */
package mips_isa_pkg;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		op_r_type = 6'h00,
		op_j = 6'h02,
		op_beq = 6'h04,
		op_addi = 6'h08,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_e;

	// r-type funct field
	typedef enum logic [5:0] {
		fn_break = 6'h0d, // halts the core
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_e;

	// what the fsm asks of the alu, funct defers to the instruction
	typedef enum logic [1:0] {cls_add, cls_sub, cls_funct} alu_class_e;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // unused, no shifts
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} j_fmt_t;

	// one instruction word, read through whichever format applies
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

endpackage

/* rtl/mips_mem.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_mem (
	input logic clk,
	input logic host_owns,
	input logic [9:0] core_addr,
	input logic [31:0] core_wdata,
	input logic core_we,
	input logic [9:0] host_addr,
	input logic [31:0] host_wdata,
	input logic [3:0] host_wstrb,
	input logic host_we,
	output logic [31:0] rdata
);

	logic [31:0] mem [`mips_mem_words];
	logic [9:0] addr;

	assign addr = host_owns ? host_addr : core_addr; // single port, owner drives

	always_ff @(posedge clk) begin
		if (host_owns && host_we) begin
			for (int b = 0; b < 4; b++)
				if (host_wstrb[b])
					mem[addr][8*b +: 8] <= host_wdata[8*b +: 8];
		end else if (!host_owns && core_we) begin
			mem[addr] <= core_wdata; // full words only
		end
		rdata <= mem[addr];
	end

endmodule

/* rtl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
	input logic clk,
	input logic rstb,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic [31:0] wd,
	input logic we,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd; // $zero never written
		end
	end

	// combinational read ports
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

/* rtl/mips_settings.svh */
`ifndef mips_settings_svh
`define mips_settings_svh

// core reset vector, lands on word 0 as memory decodes only bits 11:2
`define mips_reset_pc 32'h0000_4000

// shared word memory depth
`define mips_mem_words 1024

// host register map, byte offsets
`define mips_reg_ctrl 'h000
`define mips_reg_status 'h004
`define mips_reg_retired 'h008
`define mips_reg_pc 'h00C

// memory window, mips_mem_base up to base + 4 * words - 1
`define mips_mem_base 'h1000

`define mips_axil_addr_w 13 // host byte address width

`endif

/* rtl/mips_system.sv */
`timescale 1ns/1ps

module mips_system
	import mips_bus_pkg::*;
(
	input logic clk,
	input logic rstb,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output logic halted
);

	logic start, busy, retire;
	logic host_owns, host_we, core_we;
	logic [31:0] pc, core_addr, core_wdata, host_wdata, mem_rdata;
	logic [9:0] host_addr;
	logic [3:0] host_wstrb;

	mips_host_regs i_mips_host_regs (
		.clk(clk),
		.rstb(rstb),
		.req(axil_req),
		.rsp(axil_rsp),
		.start(start),
		.busy(busy),
		.halted(halted),
		.retire(retire),
		.pc(pc),
		.host_owns(host_owns),
		.mem_addr(host_addr),
		.mem_wdata(host_wdata),
		.mem_wstrb(host_wstrb),
		.mem_we(host_we),
		.mem_rdata(mem_rdata)
	);

	mips_mem i_mips_mem (
		.clk(clk),
		.host_owns(host_owns),
		.core_addr(core_addr[11:2]), // 0x4000 aliases to word 0
		.core_wdata(core_wdata),
		.core_we(core_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_wstrb(host_wstrb),
		.host_we(host_we),
		.rdata(mem_rdata)
	);

	mips_core i_mips_core (
		.clk(clk),
		.rstb(rstb),
		.start(start),
		.mem_rd_data(mem_rdata),
		.mem_addr(core_addr),
		.mem_wr_data(core_wdata),
		.mem_wr_ena(core_we),
		.busy(busy),
		.halted(halted),
		.retire(retire),
		.pc(pc)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mips_tb -o mips_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/mips_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^SIMULATION PASSED$'; then
	exit 0
fi
exit 1

/* sim/mips_tb.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_tb
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;
();

	localparam int n_alu_progs = 20;
	localparam int alu_ops = 30;
	localparam int alu_prog_len = alu_ops + 8; // 7 stores + break
	localparam int n_lb_progs = 5;
	localparam int n_beq = 8;
	localparam int n_poison = 3;
	localparam int lb_prog_len = 7 + 2 * n_beq + 1 + n_poison + 8;
	localparam int total_instr = (n_alu_progs + 1) * alu_prog_len + n_lb_progs * lb_prog_len;
	localparam int n_phases = 2 * (n_alu_progs + 1 + n_lb_progs) + 1; // load + readback, bus test
	localparam int timeout_cycles = 2 * (5 * total_instr + 200 * n_phases);

	localparam int result_word = 512; // sw targets, byte 0x800
	localparam int data_word = 768; // lw source words
	localparam int guard_word = 900; // target of the refused write
	localparam logic [1:0] okay = 2'b00;
	localparam logic [1:0] slverr = 2'b10;

	logic clk;
	logic rstb;
	axil_req_t req;
	axil_rsp_t rsp;
	logic halted;
	int cycle_cnt = 0;
	int errors = 0;
	int checks = 0;

	logic [31:0] model_mem [`mips_mem_words]; // mirror of the shared memory
	logic [31:0] model_reg [32];
	logic [31:0] prog [$];

	mips_system i_mips_system (
		.clk(clk),
		.rstb(rstb),
		.axil_req(req),
		.axil_rsp(rsp),
		.halted(halted)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles) begin
			$display("timeout after %0d cycles, core or bus stopped responding", cycle_cnt);
			$display("checks %0d errors %0d", checks, errors);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic logic [12:0] win_addr(input int word);
		return 13'(`mips_mem_base + 4 * word);
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'($urandom_range(7, 1)); // registers 1 to 7 only
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		instr_u w;
		w = '0;
		w.r.opcode = op_r_type;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm16 = imm;
		return w;
	endfunction

	// jump to a program word index
	function automatic logic [31:0] enc_j(input int index);
		instr_u w;
		w.j.opcode = op_j;
		w.j.target26 = 26'((`mips_reset_pc >> 2) + index);
		return w;
	endfunction

	// host accesses are entered and left 1 ns after a rising edge
	task automatic axi_write(input logic [12:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		bit hs;
		int delay;
		req.awaddr = addr;
		req.wdata = data;
		req.wstrb = strb;
		req.awvalid = 1'b1;
		req.wvalid = 1'b1;
		req.bready = 1'b0;
		do begin
			@(negedge clk);
			hs = rsp.awready; // combinational, settled by mid cycle
			check_value("axi wready", 32'(rsp.awready), 32'(rsp.wready)); // pulse together
			@(posedge clk);
			#1;
		end while (!hs);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		delay = int'($urandom_range(2, 0)); // bvalid must wait for bready
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		req.bready = 1'b1;
		do begin
			@(negedge clk);
			hs = rsp.bvalid;
			resp = rsp.bresp;
			@(posedge clk);
			#1;
		end while (!hs);
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [12:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		bit hs;
		int delay;
		req.araddr = addr;
		req.arvalid = 1'b1;
		do begin
			@(negedge clk);
			hs = rsp.arready;
			@(posedge clk);
			#1;
		end while (!hs);
		req.arvalid = 1'b0;
		delay = int'($urandom_range(2, 0)); // rvalid and rdata held meanwhile
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		req.rready = 1'b1;
		do begin
			@(negedge clk);
			hs = rsp.rvalid; // one or two cycles later
			data = rsp.rdata;
			resp = rsp.rresp;
			@(posedge clk);
			#1;
		end while (!hs);
		req.rready = 1'b0;
	endtask

	task automatic check_write(input string name, input logic [12:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, strb, resp);
		check_value({name, " bresp"}, 32'(exp_resp), 32'(resp));
	endtask

	task automatic check_read(input string name, input logic [12:0] addr,
		input logic [31:0] exp_data, input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_value({name, " rresp"}, 32'(exp_resp), 32'(resp));
		check_value({name, " rdata"}, exp_data, data);
	endtask

	task automatic write_word(input int word, input logic [31:0] data);
		check_write($sformatf("load word %0d", word), win_addr(word), data, 4'hf, okay);
		model_mem[word] = data;
	endtask

	task automatic load_program();
		for (int k = 0; k < prog.size(); k++)
			write_word(k, prog[k]); // pc 0x4000 is word 0
	endtask

	task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
		if (idx != 5'd0)
			model_reg[idx] = val;
	endtask

	// isa interpreter over the model memory and registers
	task automatic run_model(output int retired, output logic [31:0] break_pc);
		logic [31:0] pc, npc, a, b, sx, ea;
		instr_u w;
		bit done;
		int steps;
		pc = `mips_reset_pc;
		retired = 0;
		break_pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 10000) begin
			w = model_mem[pc[11:2]];
			a = model_reg[w.i.rs];
			b = model_reg[w.i.rt];
			sx = {{16{w.i.imm16[15]}}, w.i.imm16};
			ea = a + sx;
			npc = pc + 32'd4; // no delay slot
			case (w.r.opcode)
				op_r_type: begin
					case (w.r.funct)
						fn_add: set_reg(w.r.rd, a + b);
						fn_sub: set_reg(w.r.rd, a - b);
						fn_and: set_reg(w.r.rd, a & b);
						fn_or: set_reg(w.r.rd, a | b);
						fn_slt: set_reg(w.r.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: done = 1'b1; // break
					endcase
				end
				op_addi: set_reg(w.i.rt, ea);
				op_lw: set_reg(w.i.rt, model_mem[ea[11:2]]);
				op_sw: model_mem[ea[11:2]] = b;
				op_beq: begin
					if (a == b)
						npc = npc + {sx[29:0], 2'b00};
				end
				op_j: npc = {npc[31:28], w.j.target26, 2'b00};
				default: done = 1'b1; // unknown opcode halts too
			endcase
			if (done) begin
				break_pc = pc;
			end else begin
				retired++;
				pc = npc;
			end
			steps++;
		end
		if (!done) begin
			errors++;
			$display("model did not reach a break within %0d steps", steps);
		end
	endtask

	task automatic start_core(input string name);
		check_write({name, " start"}, 13'(`mips_reg_ctrl), 32'd1, 4'hf, okay);
	endtask

	task automatic wait_halted();
		@(negedge clk);
		while (!halted)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic check_results(input string name, input int retired_exp,
		input logic [31:0] break_pc);
		for (int r = 1; r < 8; r++)
			check_read($sformatf("%s r%0d", name, r), win_addr(result_word + r - 1),
				model_reg[r], okay);
		check_read({name, " retired"}, 13'(`mips_reg_retired), 32'(retired_exp), okay);
		check_read({name, " pc"}, 13'(`mips_reg_pc), break_pc, okay);
		check_read({name, " status"}, 13'(`mips_reg_status), 32'd1, okay); // halted, not busy
	endtask

	// store r1..r7 into the result area, then break
	task automatic add_epilogue();
		for (int r = 1; r < 8; r++)
			prog.push_back(enc_i(op_sw, 5'd0, 5'(r), 16'(4 * (result_word + r - 1))));
		prog.push_back(enc_r(fn_break, 5'd0, 5'd0, 5'd0));
	endtask

	task automatic gen_alu_prog();
		logic [5:0] fns [5];
		int op;
		fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
		prog.delete();
		for (int i = 0; i < alu_ops; i++) begin
			op = int'($urandom_range(5, 0));
			if (op == 5)
				prog.push_back(enc_i(op_addi, pick_reg(), pick_reg(), 16'($urandom)));
			else
				prog.push_back(enc_r(fns[op], pick_reg(), pick_reg(), pick_reg()));
		end
		add_epilogue();
	endtask

	task automatic gen_lb_prog();
		logic [4:0] rs, rt, rd;
		int target;
		prog.delete();
		for (int k = 0; k < 16; k++)
			write_word(data_word + k, 32'($urandom_range(3, 0))); // small, so beq hits often
		for (int r = 1; r < 8; r++)
			prog.push_back(enc_i(op_lw, 5'd0, 5'(r), 16'(4 * (data_word + $urandom_range(15, 0)))));
		for (int i = 0; i < n_beq; i++) begin
			rs = pick_reg();
			rt = ($urandom_range(3, 0) == 0) ? rs : pick_reg();
			rd = pick_reg();
			prog.push_back(enc_i(op_beq, rs, rt, 16'd1)); // skip the next word
			prog.push_back(enc_i(op_addi, rd, rd, 16'(int'($urandom_range(4, 0)) - 2)));
		end
		target = prog.size() + 1 + n_poison;
		prog.push_back(enc_j(target));
		for (int i = 0; i < n_poison; i++)
			prog.push_back(enc_i(op_addi, 5'd0, pick_reg(), 16'h7bad)); // wrecks a reg if run
		add_epilogue();
	endtask

	task automatic run_program(input string name);
		int retired_exp;
		logic [31:0] break_pc;
		load_program();
		run_model(retired_exp, break_pc);
		start_core(name);
		wait_halted();
		check_results(name, retired_exp, break_pc);
	endtask

	task automatic bus_test();
		int word;
		logic [31:0] data;
		logic [3:0] strb;
		check_read("reset status", 13'(`mips_reg_status), 32'd0, okay);
		check_read("reset retired", 13'(`mips_reg_retired), 32'd0, okay);
		check_read("reset ctrl", 13'(`mips_reg_ctrl), 32'd0, okay);
		check_read("unmapped read", 13'h0100, 32'd0, slverr);
		for (int i = 0; i < 8; i++) begin
			word = int'($urandom_range(1023, 600));
			write_word(word, $urandom);
			check_read("window read", win_addr(word), model_mem[word], okay);
			data = $urandom;
			strb = 4'($urandom_range(14, 1)); // partial strobes only
			check_write("window strobe write", win_addr(word), data, strb, okay);
			for (int b = 0; b < 4; b++)
				if (strb[b])
					model_mem[word][8*b +: 8] = data[8*b +: 8];
			check_read("window merge", win_addr(word), model_mem[word], okay);
		end
	endtask

	task automatic busy_test();
		int retired_exp;
		logic [31:0] break_pc;
		write_word(guard_word, $urandom);
		gen_alu_prog();
		load_program();
		run_model(retired_exp, break_pc);
		start_core("busy");
		check_read("busy status", 13'(`mips_reg_status), 32'd2, okay);
		check_write("busy window write", win_addr(guard_word), ~model_mem[guard_word], 4'hf,
			slverr);
		check_write("busy restart", 13'(`mips_reg_ctrl), 32'd1, 4'hf, okay); // must be ignored
		wait_halted();
		check_results("busy", retired_exp, break_pc);
		check_read("busy guard word", win_addr(guard_word), model_mem[guard_word], okay);
	endtask

	initial begin
		void'($urandom(85));
		req = '0;
		rstb = 1'b0;
		for (int r = 0; r < 32; r++)
			model_reg[r] = '0; // regfile reset clears all
		repeat (3) @(posedge clk);
		#1;
		rstb = 1'b1;
		bus_test();
		for (int p = 0; p < n_alu_progs; p++) begin
			gen_alu_prog();
			run_program($sformatf("alu prog %0d", p));
		end
		for (int p = 0; p < n_lb_progs; p++) begin
			gen_lb_prog();
			run_program($sformatf("load branch prog %0d", p));
		end
		busy_test();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sim/mips_tb_assertions.sv */
`timescale 1ns/1ps

module mips_tb_assertions
	import mips_bus_pkg::*;
(
	input logic clk,
	input logic rstb,
	input axil_req_t req,
	input axil_rsp_t rsp,
	input logic halted,
	input logic busy,
	input logic core_we
);

	// write response waits for bready
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstb)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
		else $error("bvalid dropped before bready");

	// read response and data held until rready
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstb)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
		else $error("rvalid or rdata changed before rready");

	a_no_write_halted: assert property (@(posedge clk) disable iff (!rstb)
		halted |-> !core_we)
		else $error("core memory write while halted");

	a_busy_halted: assert property (@(posedge clk) disable iff (!rstb)
		!(busy && halted))
		else $error("busy and halted both high");

endmodule

bind mips_system mips_tb_assertions i_mips_tb_assertions (
	.clk(clk),
	.rstb(rstb),
	.req(axil_req),
	.rsp(axil_rsp),
	.halted(halted),
	.busy(busy),
	.core_we(core_we)
);
